/* Bender.yml */
package:
  name: sr_cpu

sources:
  - files:
      - src/rv_isa_pkg.sv
      - src/serial_core_pkg.sv
      - src/sr_decode.sv
      - src/sr_state.sv
      - src/sr_ctrl.sv
      - src/sr_alu.sv
      - src/sr_store.sv
      - src/sr_regfile.sv
      - src/sr_core.sv
      - src/sr_cpu.sv
  - target: test
    files:
      - tb/sr_cpu_chk.sv
      - tb/sr_cpu_tb.sv

/* flist.f */
src/rv_isa_pkg.sv
src/serial_core_pkg.sv
src/sr_decode.sv
src/sr_state.sv
src/sr_ctrl.sv
src/sr_alu.sv
src/sr_store.sv
src/sr_regfile.sv
src/sr_core.sv
src/sr_cpu.sv
tb/sr_cpu_chk.sv
tb/sr_cpu_tb.sv

/* src/rv_isa_pkg.sv */
package rv_isa_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_addr_t;

   // Major opcodes of the kept subset
   typedef enum logic [6:0] {
      OPC_LUI    = 7'b0110111,
      OPC_JAL    = 7'b1101111,
      OPC_BRANCH = 7'b1100011,
      OPC_STORE  = 7'b0100011,
      OPC_OP_IMM = 7'b0010011,
      OPC_OP     = 7'b0110011
   } opcode_e;

   typedef enum logic [2:0] {
      F3_ADD_SUB_BEQ = 3'b000,
      F3_BNE         = 3'b001,
      F3_SW          = 3'b010,
      F3_XOR         = 3'b100,
      F3_OR          = 3'b110,
      F3_AND         = 3'b111
   } funct3_e;

endpackage

/* src/serial_core_pkg.sv */
package serial_core_pkg;

   // One bit per cycle over a 32-bit word
   localparam int CNT_W = 5;

   typedef enum logic [2:0] {
      ST_FETCH,
      ST_DECODE,
      ST_COMPARE,
      ST_EXECUTE,
      ST_STORE
   } state_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_XOR,
      ALU_OR,
      ALU_AND
   } alu_op_e;

   typedef enum logic [1:0] {
      RD_ALU,
      RD_IMM,
      RD_PC4
   } rd_src_e;

endpackage

/* src/sr_alu.sv */
`timescale 1ns/1ns

module sr_alu (
   input  logic                              clk,
   input  logic                              i_rst_n,
   input  logic                              i_cnt_en,
   input  logic [serial_core_pkg::CNT_W-1:0] i_cnt,
   input  serial_core_pkg::alu_op_e          i_op,
   input  logic                              i_rs1,
   input  logic                              i_op_b,
   output logic                              o_rd,
   output logic                              o_sum,
   output logic                              o_cmp_eq
);

   logic sub;
   logic b;
   logic c_in;
   logic carry;

   assign sub   = (i_op == serial_core_pkg::ALU_SUB);
   assign b     = i_op_b ^ sub;
   // Subtract starts from a carry of one
   assign c_in  = (i_cnt == '0) ? sub : carry;
   assign o_sum = i_rs1 ^ b ^ c_in;

   always_comb begin
      case (i_op)
         serial_core_pkg::ALU_XOR: o_rd = i_rs1 ^ i_op_b;
         serial_core_pkg::ALU_OR:  o_rd = i_rs1 | i_op_b;
         serial_core_pkg::ALU_AND: o_rd = i_rs1 & i_op_b;
         default:                  o_rd = o_sum;
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         carry    <= 1'b0;
         o_cmp_eq <= 1'b0;
      end else if (i_cnt_en) begin
         carry    <= (i_rs1 & b) | (c_in & (i_rs1 ^ b));
         o_cmp_eq <= (i_rs1 == i_op_b) && ((i_cnt == '0) || o_cmp_eq);
      end
   end

endmodule

/* src/sr_core.sv */
`timescale 1ns/1ns

module sr_core #(
   parameter rv_isa_pkg::word_t RESET_PC = '0
) (
   input  logic                              clk,
   input  logic                              i_rst_n,
   output logic                              o_ibus_cyc,
   output rv_isa_pkg::word_t                 o_ibus_adr,
   input  rv_isa_pkg::word_t                 i_ibus_rdt,
   input  logic                              i_ibus_ack,
   output logic                              o_dbus_cyc,
   output rv_isa_pkg::word_t                 o_dbus_adr,
   output rv_isa_pkg::word_t                 o_dbus_dat,
   input  logic                              i_dbus_ack,
   output rv_isa_pkg::reg_addr_t             o_rf_rs1_addr,
   output rv_isa_pkg::reg_addr_t             o_rf_rs2_addr,
   output rv_isa_pkg::reg_addr_t             o_rf_rd_addr,
   output logic [serial_core_pkg::CNT_W-1:0] o_rf_cnt,
   output logic                              o_rf_wen,
   output logic                              o_rf_wdata,
   input  logic                              i_rf_rs1,
   input  logic                              i_rf_rs2
);

   serial_core_pkg::alu_op_e alu_op;
   serial_core_pkg::rd_src_e rd_src;
   logic use_imm;
   logic rd_write;
   logic branch;
   logic branch_ne;
   logic jump;
   logic store;
   logic imm;
   logic cnt_en;
   logic compare;
   logic alu_en;
   logic op_b;
   logic alu_rd;
   logic sum;
   logic cmp_eq;
   logic take;
   logic pc4_bit;

   assign op_b   = use_imm ? imm : i_rf_rs2;
   assign take   = jump || (branch && (cmp_eq != branch_ne));
   // Keep the compare result frozen while a branch executes
   assign alu_en = cnt_en && (compare || !branch);

   always_comb begin
      case (rd_src)
         serial_core_pkg::RD_IMM: o_rf_wdata = imm;
         serial_core_pkg::RD_PC4: o_rf_wdata = pc4_bit;
         default:                 o_rf_wdata = alu_rd;
      endcase
   end

   sr_decode decode (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_ibus_rdt  (i_ibus_rdt),
      .i_ibus_ack  (i_ibus_ack),
      .i_cnt_en    (cnt_en),
      .o_rs1_addr  (o_rf_rs1_addr),
      .o_rs2_addr  (o_rf_rs2_addr),
      .o_rd_addr   (o_rf_rd_addr),
      .o_alu_op    (alu_op),
      .o_use_imm   (use_imm),
      .o_rd_src    (rd_src),
      .o_rd_write  (rd_write),
      .o_branch    (branch),
      .o_branch_ne (branch_ne),
      .o_jump      (jump),
      .o_store     (store),
      .o_imm       (imm)
   );

   sr_state state (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_ack (i_dbus_ack),
      .i_branch   (branch),
      .i_store    (store),
      .i_rd_write (rd_write),
      .o_ibus_cyc (o_ibus_cyc),
      .o_dbus_cyc (o_dbus_cyc),
      .o_cnt_en   (cnt_en),
      .o_cnt      (o_rf_cnt),
      .o_compare  (compare),
      .o_rf_wen   (o_rf_wen)
   );

   sr_ctrl #(
      .RESET_PC (RESET_PC)
   ) ctrl (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt_en   (cnt_en),
      .i_compare  (compare),
      .i_cnt      (o_rf_cnt),
      .i_imm      (imm),
      .i_take     (take),
      .o_pc_bit   (),
      .o_pc4_bit  (pc4_bit),
      .o_ibus_adr (o_ibus_adr)
   );

   sr_alu alu (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_cnt_en (alu_en),
      .i_cnt    (o_rf_cnt),
      .i_op     (alu_op),
      .i_rs1    (i_rf_rs1),
      .i_op_b   (op_b),
      .o_rd     (alu_rd),
      .o_sum    (sum),
      .o_cmp_eq (cmp_eq)
   );

   // Address is rs1 plus the S immediate from the adder
   sr_store store_buf (
      .clk        (clk),
      .i_cnt_en   (cnt_en),
      .i_store    (store),
      .i_addr_bit (sum),
      .i_data_bit (i_rf_rs2),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat)
   );

endmodule

/* src/sr_cpu.sv */
`timescale 1ns/1ns

module sr_cpu #(
   parameter rv_isa_pkg::word_t RESET_PC = '0
) (
   input  logic              clk,
   input  logic              i_rst_n,
   output logic              o_ibus_cyc,
   output rv_isa_pkg::word_t o_ibus_adr,
   input  rv_isa_pkg::word_t i_ibus_rdt,
   input  logic              i_ibus_ack,
   output logic              o_dbus_cyc,
   output rv_isa_pkg::word_t o_dbus_adr,
   output rv_isa_pkg::word_t o_dbus_dat,
   input  logic              i_dbus_ack
);

   rv_isa_pkg::reg_addr_t             rs1_addr;
   rv_isa_pkg::reg_addr_t             rs2_addr;
   rv_isa_pkg::reg_addr_t             rd_addr;
   logic [serial_core_pkg::CNT_W-1:0] cnt;
   logic                              wen;
   logic                              wdata;
   logic                              rs1;
   logic                              rs2;

   sr_core #(
      .RESET_PC (RESET_PC)
   ) core (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .o_ibus_cyc    (o_ibus_cyc),
      .o_ibus_adr    (o_ibus_adr),
      .i_ibus_rdt    (i_ibus_rdt),
      .i_ibus_ack    (i_ibus_ack),
      .o_dbus_cyc    (o_dbus_cyc),
      .o_dbus_adr    (o_dbus_adr),
      .o_dbus_dat    (o_dbus_dat),
      .i_dbus_ack    (i_dbus_ack),
      .o_rf_rs1_addr (rs1_addr),
      .o_rf_rs2_addr (rs2_addr),
      .o_rf_rd_addr  (rd_addr),
      .o_rf_cnt      (cnt),
      .o_rf_wen      (wen),
      .o_rf_wdata    (wdata),
      .i_rf_rs1      (rs1),
      .i_rf_rs2      (rs2)
   );

   sr_regfile regfile (
      .clk        (clk),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_addr  (rd_addr),
      .i_cnt      (cnt),
      .i_wen      (wen),
      .i_wdata    (wdata),
      .o_rs1      (rs1),
      .o_rs2      (rs2)
   );

endmodule

/* src/sr_ctrl.sv */
`timescale 1ns/1ns

module sr_ctrl #(
   parameter rv_isa_pkg::word_t RESET_PC = '0
) (
   input  logic                              clk,
   input  logic                              i_rst_n,
   input  logic                              i_cnt_en,
   input  logic                              i_compare,
   input  logic [serial_core_pkg::CNT_W-1:0] i_cnt,
   input  logic                              i_imm,
   input  logic                              i_take,
   output logic                              o_pc_bit,
   output logic                              o_pc4_bit,
   output rv_isa_pkg::word_t                 o_ibus_adr
);

   rv_isa_pkg::word_t pc;
   logic              en;
   logic              four;
   logic              op;
   logic              c_new;
   logic              c_pc4;
   logic              cy_new;
   logic              cy_pc4;
   logic              new_bit;

   assign en         = i_cnt_en && !i_compare;
   assign four       = (i_cnt == 2);
   assign op         = i_take ? i_imm : four;
   assign c_new      = (i_cnt == '0) ? 1'b0 : cy_new;
   assign c_pc4      = (i_cnt == '0) ? 1'b0 : cy_pc4;
   assign new_bit    = pc[0] ^ op ^ c_new;
   assign o_pc4_bit  = pc[0] ^ four ^ c_pc4;
   assign o_pc_bit   = pc[0];
   assign o_ibus_adr = pc;

   // Next PC enters at the top as the old one leaves at bit 0
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc     <= RESET_PC;
         cy_new <= 1'b0;
         cy_pc4 <= 1'b0;
      end else if (en) begin
         pc     <= {new_bit, pc[31:1]};
         cy_new <= (pc[0] & op) | (c_new & (pc[0] ^ op));
         cy_pc4 <= (pc[0] & four) | (c_pc4 & (pc[0] ^ four));
      end
   end

endmodule

/* src/sr_decode.sv */
`timescale 1ns/1ns

module sr_decode (
   input  logic                     clk,
   input  logic                     i_rst_n,
   input  rv_isa_pkg::word_t        i_ibus_rdt,
   input  logic                     i_ibus_ack,
   input  logic                     i_cnt_en,
   output rv_isa_pkg::reg_addr_t    o_rs1_addr,
   output rv_isa_pkg::reg_addr_t    o_rs2_addr,
   output rv_isa_pkg::reg_addr_t    o_rd_addr,
   output serial_core_pkg::alu_op_e o_alu_op,
   output logic                     o_use_imm,
   output serial_core_pkg::rd_src_e o_rd_src,
   output logic                     o_rd_write,
   output logic                     o_branch,
   output logic                     o_branch_ne,
   output logic                     o_jump,
   output logic                     o_store,
   output logic                     o_imm
);

   rv_isa_pkg::word_t   ir;
   rv_isa_pkg::word_t   imm_q;
   rv_isa_pkg::word_t   imm_d;
   rv_isa_pkg::opcode_e opcode;
   rv_isa_pkg::funct3_e funct3;

   assign opcode      = rv_isa_pkg::opcode_e'(ir[6:0]);
   assign funct3      = rv_isa_pkg::funct3_e'(ir[14:12]);
   assign o_rs1_addr  = ir[19:15];
   assign o_rs2_addr  = ir[24:20];
   assign o_rd_addr   = ir[11:7];
   assign o_branch_ne = (funct3 == rv_isa_pkg::F3_BNE);
   assign o_imm       = imm_q[0];

   // Immediate format follows the opcode of the word on the bus
   always_comb begin
      case (rv_isa_pkg::opcode_e'(i_ibus_rdt[6:0]))
         rv_isa_pkg::OPC_STORE:
            imm_d = {{20{i_ibus_rdt[31]}}, i_ibus_rdt[31:25], i_ibus_rdt[11:7]};
         rv_isa_pkg::OPC_BRANCH:
            imm_d = {{20{i_ibus_rdt[31]}}, i_ibus_rdt[7], i_ibus_rdt[30:25],
                     i_ibus_rdt[11:8], 1'b0};
         rv_isa_pkg::OPC_JAL:
            imm_d = {{12{i_ibus_rdt[31]}}, i_ibus_rdt[19:12], i_ibus_rdt[20],
                     i_ibus_rdt[30:21], 1'b0};
         rv_isa_pkg::OPC_LUI:
            imm_d = {i_ibus_rdt[31:12], 12'h000};
         default:
            imm_d = {{20{i_ibus_rdt[31]}}, i_ibus_rdt[31:20]};
      endcase
   end

   always_comb begin
      o_alu_op   = serial_core_pkg::ALU_ADD;
      o_use_imm  = 1'b0;
      o_rd_src   = serial_core_pkg::RD_ALU;
      o_rd_write = 1'b0;
      o_branch   = 1'b0;
      o_jump     = 1'b0;
      o_store    = 1'b0;
      case (opcode)
         rv_isa_pkg::OPC_LUI: begin
            o_rd_src   = serial_core_pkg::RD_IMM;
            o_rd_write = 1'b1;
         end
         rv_isa_pkg::OPC_JAL: begin
            o_rd_src   = serial_core_pkg::RD_PC4;
            o_rd_write = 1'b1;
            o_jump     = 1'b1;
         end
         rv_isa_pkg::OPC_BRANCH: begin
            o_branch = (funct3 == rv_isa_pkg::F3_ADD_SUB_BEQ) || o_branch_ne;
         end
         rv_isa_pkg::OPC_STORE: begin
            o_use_imm = 1'b1;
            o_store   = (funct3 == rv_isa_pkg::F3_SW);
         end
         rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_OP: begin
            o_use_imm  = (opcode == rv_isa_pkg::OPC_OP_IMM);
            o_rd_write = 1'b1;
            case (funct3)
               rv_isa_pkg::F3_ADD_SUB_BEQ:
                  o_alu_op = (!o_use_imm && ir[30]) ? serial_core_pkg::ALU_SUB
                                                    : serial_core_pkg::ALU_ADD;
               rv_isa_pkg::F3_XOR: o_alu_op = serial_core_pkg::ALU_XOR;
               rv_isa_pkg::F3_OR:  o_alu_op = serial_core_pkg::ALU_OR;
               rv_isa_pkg::F3_AND: o_alu_op = serial_core_pkg::ALU_AND;
               // Shifts and set-less-than retire without a write
               default:            o_rd_write = 1'b0;
            endcase
         end
         default: begin
         end
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         ir <= '0;
      end else if (i_ibus_ack) begin
         ir <= i_ibus_rdt;
      end
   end

   // Rotates, so 32 compare cycles leave it ready for execute
   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         imm_q <= imm_d;
      end else if (i_cnt_en) begin
         imm_q <= {imm_q[0], imm_q[31:1]};
      end
   end

endmodule

/* src/sr_regfile.sv */
`timescale 1ns/1ns

module sr_regfile (
   input  logic                              clk,
   input  rv_isa_pkg::reg_addr_t             i_rs1_addr,
   input  rv_isa_pkg::reg_addr_t             i_rs2_addr,
   input  rv_isa_pkg::reg_addr_t             i_rd_addr,
   input  logic [serial_core_pkg::CNT_W-1:0] i_cnt,
   input  logic                              i_wen,
   input  logic                              i_wdata,
   output logic                              o_rs1,
   output logic                              o_rs2
);

   rv_isa_pkg::word_t regs [32];

   // x0 is hardwired to zero
   assign o_rs1 = (i_rs1_addr == '0) ? 1'b0 : regs[i_rs1_addr][i_cnt];
   assign o_rs2 = (i_rs2_addr == '0) ? 1'b0 : regs[i_rs2_addr][i_cnt];

   always_ff @(posedge clk) begin
      if (i_wen && (i_rd_addr != '0)) begin
         regs[i_rd_addr][i_cnt] <= i_wdata;
      end
   end

endmodule

/* src/sr_state.sv */
`timescale 1ns/1ns

module sr_state (
   input  logic                              clk,
   input  logic                              i_rst_n,
   input  logic                              i_ibus_ack,
   input  logic                              i_dbus_ack,
   input  logic                              i_branch,
   input  logic                              i_store,
   input  logic                              i_rd_write,
   output logic                              o_ibus_cyc,
   output logic                              o_dbus_cyc,
   output logic                              o_cnt_en,
   output logic [serial_core_pkg::CNT_W-1:0] o_cnt,
   output logic                              o_compare,
   output logic                              o_rf_wen
);

   serial_core_pkg::state_e state;
   logic                    last;

   assign last      = &o_cnt;
   assign o_compare = (state == serial_core_pkg::ST_COMPARE);
   assign o_cnt_en  = o_compare || (state == serial_core_pkg::ST_EXECUTE);
   assign o_rf_wen  = (state == serial_core_pkg::ST_EXECUTE) && i_rd_write;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state      <= serial_core_pkg::ST_FETCH;
         o_cnt      <= '0;
         o_ibus_cyc <= 1'b0;
         o_dbus_cyc <= 1'b0;
      end else begin
         if (o_cnt_en) begin
            o_cnt <= o_cnt + 1'b1;
         end
         case (state)
            serial_core_pkg::ST_FETCH: begin
               // Only the first fetch after reset enters with cyc low
               if (!o_ibus_cyc) begin
                  o_ibus_cyc <= 1'b1;
               end else if (i_ibus_ack) begin
                  o_ibus_cyc <= 1'b0;
                  state      <= serial_core_pkg::ST_DECODE;
               end
            end
            serial_core_pkg::ST_DECODE: begin
               state <= i_branch ? serial_core_pkg::ST_COMPARE : serial_core_pkg::ST_EXECUTE;
            end
            serial_core_pkg::ST_COMPARE: begin
               if (last) begin
                  state <= serial_core_pkg::ST_EXECUTE;
               end
            end
            serial_core_pkg::ST_EXECUTE: begin
               if (last && i_store) begin
                  state      <= serial_core_pkg::ST_STORE;
                  o_dbus_cyc <= 1'b1;
               end else if (last) begin
                  state      <= serial_core_pkg::ST_FETCH;
                  o_ibus_cyc <= 1'b1;
               end
            end
            default: begin
               if (i_dbus_ack) begin
                  o_dbus_cyc <= 1'b0;
                  o_ibus_cyc <= 1'b1;
                  state      <= serial_core_pkg::ST_FETCH;
               end
            end
         endcase
      end
   end

endmodule

/* src/sr_store.sv */
`timescale 1ns/1ns

module sr_store (
   input  logic              clk,
   input  logic              i_cnt_en,
   input  logic              i_store,
   input  logic              i_addr_bit,
   input  logic              i_data_bit,
   output rv_isa_pkg::word_t o_dbus_adr,
   output rv_isa_pkg::word_t o_dbus_dat
);

   logic shift;

   assign shift = i_cnt_en && i_store;

   // LSB first, so the word is complete after the last execute cycle
   always_ff @(posedge clk) begin
      if (shift) begin
         o_dbus_adr <= {i_addr_bit, o_dbus_adr[31:1]};
         o_dbus_dat <= {i_data_bit, o_dbus_dat[31:1]};
      end
   end

endmodule

/* tb/sr_cpu_chk.sv */
`timescale 1ns/1ns

module sr_cpu_chk (
   input logic              clk,
   input logic              i_rst_n,
   input logic              i_ibus_cyc,
   input rv_isa_pkg::word_t i_ibus_adr,
   input logic              i_ibus_ack,
   input logic              i_dbus_cyc,
   input rv_isa_pkg::word_t i_dbus_adr,
   input rv_isa_pkg::word_t i_dbus_dat,
   input logic              i_dbus_ack
);

   int fail_cnt = 0;

   // Request held with a steady address until the ack
   ibus_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_ibus_cyc && !i_ibus_ack |=> i_ibus_cyc && $stable(i_ibus_adr))
      else begin
         $error("ibus cyc dropped or address moved before ack");
         fail_cnt = fail_cnt + 1;
      end

   ibus_drop: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_ibus_cyc && i_ibus_ack |=> !i_ibus_cyc)
      else begin
         $error("ibus cyc still high after its ack");
         fail_cnt = fail_cnt + 1;
      end

   dbus_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_dbus_cyc && !i_dbus_ack |=> i_dbus_cyc && $stable(i_dbus_adr) && $stable(i_dbus_dat))
      else begin
         $error("dbus cyc dropped or address/data moved before ack");
         fail_cnt = fail_cnt + 1;
      end

   dbus_drop: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_dbus_cyc && i_dbus_ack |=> !i_dbus_cyc)
      else begin
         $error("dbus cyc still high after its ack");
         fail_cnt = fail_cnt + 1;
      end

   // One bus at a time
   one_bus: assert property (@(posedge clk) disable iff (!i_rst_n)
      !(i_ibus_cyc && i_dbus_cyc))
      else begin
         $error("ibus and dbus cycles active together");
         fail_cnt = fail_cnt + 1;
      end

   reset_idle: assert property (@(posedge clk)
      !i_rst_n |-> !i_ibus_cyc && !i_dbus_cyc)
      else begin
         $error("bus cycle active during reset");
         fail_cnt = fail_cnt + 1;
      end

endmodule

bind sr_cpu sr_cpu_chk bus_chk (
   .clk        (clk),
   .i_rst_n    (i_rst_n),
   .i_ibus_cyc (o_ibus_cyc),
   .i_ibus_adr (o_ibus_adr),
   .i_ibus_ack (i_ibus_ack),
   .i_dbus_cyc (o_dbus_cyc),
   .i_dbus_adr (o_dbus_adr),
   .i_dbus_dat (o_dbus_dat),
   .i_dbus_ack (i_dbus_ack)
);

/* tb/sr_cpu_tb.sv */
`timescale 1ns/1ns

module sr_cpu_tb;

   localparam int CLK_PERIOD = 4;
   localparam rv_isa_pkg::word_t START_PC = 32'h0000_0080;
   localparam int IMEM_WORDS = 64;
   localparam int CYC_PER_INSTR = 70;
   localparam int CHECK_CYCLES = 20 * CYC_PER_INSTR;
   // Instructions over all programs, stalled reruns included
   localparam int TEST_INSTRS = 2 + 8 + 18 + 9 + 6 + (8 + 18 + 9 + 6);
   localparam int WATCHDOG_NS = (TEST_INSTRS * CYC_PER_INSTR + 9 * 12) * CLK_PERIOD;

   logic              clk = 1'b0;
   logic              i_rst_n;
   logic              o_ibus_cyc;
   rv_isa_pkg::word_t o_ibus_adr;
   rv_isa_pkg::word_t i_ibus_rdt;
   logic              i_ibus_ack;
   logic              o_dbus_cyc;
   rv_isa_pkg::word_t o_dbus_adr;
   rv_isa_pkg::word_t o_dbus_dat;
   logic              i_dbus_ack;

   rv_isa_pkg::word_t imem [IMEM_WORDS];
   rv_isa_pkg::word_t fetch_q[$];
   rv_isa_pkg::word_t store_adr_q[$];
   rv_isa_pkg::word_t store_dat_q[$];
   int                load_idx;
   int                errors = 0;
   integer            seed;
   logic              stall_en;
   logic              run_over = 1'b0;

   sr_cpu #(
      .RESET_PC (START_PC)
   ) UUT (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .o_ibus_cyc (o_ibus_cyc),
      .o_ibus_adr (o_ibus_adr),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_dbus_cyc (o_dbus_cyc),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .i_dbus_ack (i_dbus_ack)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic rv_isa_pkg::word_t sext12(input logic [11:0] v);
      return {{20{v[11]}}, v};
   endfunction

   function automatic rv_isa_pkg::word_t op_imm(input rv_isa_pkg::funct3_e f3,
         input rv_isa_pkg::reg_addr_t rd, input rv_isa_pkg::reg_addr_t rs1,
         input logic [11:0] imm);
      return {imm, rs1, f3, rd, rv_isa_pkg::OPC_OP_IMM};
   endfunction

   function automatic rv_isa_pkg::word_t op_reg(input rv_isa_pkg::funct3_e f3,
         input logic sub, input rv_isa_pkg::reg_addr_t rd,
         input rv_isa_pkg::reg_addr_t rs1, input rv_isa_pkg::reg_addr_t rs2);
      return {1'b0, sub, 5'b00000, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
   endfunction

   function automatic rv_isa_pkg::word_t sw(input rv_isa_pkg::reg_addr_t rs2,
         input rv_isa_pkg::reg_addr_t rs1, input logic [11:0] off);
      return {off[11:5], rs2, rs1, rv_isa_pkg::F3_SW, off[4:0], rv_isa_pkg::OPC_STORE};
   endfunction

   function automatic rv_isa_pkg::word_t branch(input rv_isa_pkg::funct3_e f3,
         input rv_isa_pkg::reg_addr_t rs1, input rv_isa_pkg::reg_addr_t rs2,
         input logic [12:0] off);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_isa_pkg::OPC_BRANCH};
   endfunction

   function automatic rv_isa_pkg::word_t jal(input rv_isa_pkg::reg_addr_t rd,
         input logic [20:0] off);
      return {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::OPC_JAL};
   endfunction

   function automatic rv_isa_pkg::word_t lui(input rv_isa_pkg::reg_addr_t rd,
         input logic [19:0] imm);
      return {imm, rd, rv_isa_pkg::OPC_LUI};
   endfunction

   // Instruction memory, acked after 0 to 3 cycles when stalls are on
   always begin : ibus_responder
      int                delay;
      rv_isa_pkg::word_t adr;
      @(posedge clk);
      #1;
      if (i_rst_n && o_ibus_cyc) begin
         adr = o_ibus_adr;
         delay = stall_en ? ($random(seed) & 3) : 0;
         repeat (delay) begin
            @(posedge clk);
            #1;
         end
         if (o_ibus_cyc && o_ibus_adr == adr) begin
            i_ibus_rdt = imem[adr[7:2]];
            i_ibus_ack = 1'b1;
            fetch_q.push_back(adr);
            @(posedge clk);
            #1;
            i_ibus_ack = 1'b0;
         end else if (i_rst_n) begin
            $display("ERROR: instruction bus cycle at %08h changed before its ack", adr);
            errors++;
         end
      end
   end

   always begin : dbus_responder
      int                delay;
      rv_isa_pkg::word_t adr;
      rv_isa_pkg::word_t dat;
      @(posedge clk);
      #1;
      if (i_rst_n && o_dbus_cyc) begin
         adr = o_dbus_adr;
         dat = o_dbus_dat;
         delay = stall_en ? ($random(seed) & 3) : 0;
         repeat (delay) begin
            @(posedge clk);
            #1;
         end
         if (o_dbus_cyc && o_dbus_adr == adr && o_dbus_dat == dat) begin
            i_dbus_ack = 1'b1;
            store_adr_q.push_back(adr);
            store_dat_q.push_back(dat);
            @(posedge clk);
            #1;
            i_dbus_ack = 1'b0;
         end else if (i_rst_n) begin
            $display("ERROR: data bus cycle at %08h changed before its ack", adr);
            errors++;
         end
      end
   end

   task automatic begin_program();
      rv_isa_pkg::word_t adr;
      @(posedge clk);
      #1;
      i_rst_n = 1'b0;
      // Unknown opcode in the low bits, so a stray fetch is a no-op
      for (int i = 0; i < IMEM_WORDS; i++) begin
         adr = i * 4;
         imem[i] = {adr[24:0], 7'b0000000};
      end
      load_idx = START_PC[7:2];
   endtask

   task automatic put(input rv_isa_pkg::word_t instr);
      imem[load_idx] = instr;
      load_idx++;
   endtask

   task automatic release_program();
      repeat (10) @(posedge clk);
      #1;
      fetch_q.delete();
      store_adr_q.delete();
      store_dat_q.delete();
      i_rst_n = 1'b1;
   endtask

   task automatic check_store(input rv_isa_pkg::word_t exp_adr,
         input rv_isa_pkg::word_t exp_dat);
      int                waited;
      rv_isa_pkg::word_t adr;
      rv_isa_pkg::word_t dat;
      waited = 0;
      while (store_adr_q.size() == 0 && waited < CHECK_CYCLES) begin
         @(posedge clk);
         waited++;
      end
      if (store_adr_q.size() == 0) begin
         $display("ERROR: no data bus cycle seen for the store to %08h", exp_adr);
         errors++;
      end else begin
         adr = store_adr_q.pop_front();
         dat = store_dat_q.pop_front();
         if (adr !== exp_adr) begin
            $display("FAILED o_dbus_adr: got %08h, expected %08h", adr, exp_adr);
            errors++;
         end
         if (dat !== exp_dat) begin
            $display("FAILED o_dbus_dat: got %08h, expected %08h", dat, exp_dat);
            errors++;
         end
      end
   endtask

   task automatic check_fetch(input rv_isa_pkg::word_t exp_adr);
      int                waited;
      rv_isa_pkg::word_t adr;
      waited = 0;
      while (fetch_q.size() == 0 && waited < CHECK_CYCLES) begin
         @(posedge clk);
         waited++;
      end
      if (fetch_q.size() == 0) begin
         $display("ERROR: no instruction fetch seen where %08h was expected", exp_adr);
         errors++;
      end else begin
         adr = fetch_q.pop_front();
         if (adr !== exp_adr) begin
            $display("FAILED o_ibus_adr: got %08h, expected %08h", adr, exp_adr);
            errors++;
         end
      end
   endtask

   task automatic first_fetch();
      begin_program();
      put(jal(5'd0, 21'd0));
      release_program();
      check_fetch(START_PC);
      check_fetch(START_PC);
      if (store_adr_q.size() != 0 || o_dbus_cyc !== 1'b0) begin
         $display("ERROR: data bus active although the program has no store");
         errors++;
      end
   endtask

   task automatic arithmetic();
      rv_isa_pkg::word_t a;
      rv_isa_pkg::word_t b;
      a = sext12(12'h123);
      b = sext12(12'hFB3);
      begin_program();
      put(op_imm(rv_isa_pkg::F3_ADD_SUB_BEQ, 5'd1, 5'd0, 12'h123));
      put(op_imm(rv_isa_pkg::F3_ADD_SUB_BEQ, 5'd2, 5'd0, 12'hFB3));
      put(op_reg(rv_isa_pkg::F3_ADD_SUB_BEQ, 1'b0, 5'd3, 5'd1, 5'd2));
      put(op_reg(rv_isa_pkg::F3_ADD_SUB_BEQ, 1'b1, 5'd4, 5'd1, 5'd2));
      put(op_imm(rv_isa_pkg::F3_ADD_SUB_BEQ, 5'd5, 5'd0, 12'h200));
      put(sw(5'd3, 5'd5, 12'h008));
      put(sw(5'd4, 5'd5, 12'hFFC));
      put(jal(5'd0, 21'd0));
      release_program();
      check_store(32'h200 + 32'h8, a + b);
      check_store(32'h200 + sext12(12'hFFC), a - b);
   endtask

   task automatic logic_and_lui();
      rv_isa_pkg::word_t r1;
      rv_isa_pkg::word_t r2;
      rv_isa_pkg::word_t r3;
      rv_isa_pkg::word_t r4;
      r1 = sext12(12'h5A5);
      r2 = {20'hA5A5A, 12'h000};
      r3 = r2 ^ sext12(12'h7F0);
      r4 = r1 | sext12(12'h80F);
      begin_program();
      put(op_imm(rv_isa_pkg::F3_ADD_SUB_BEQ, 5'd1, 5'd0, 12'h5A5));
      put(lui(5'd2, 20'hA5A5A));
      put(op_imm(rv_isa_pkg::F3_XOR, 5'd3, 5'd2, 12'h7F0));
      put(op_imm(rv_isa_pkg::F3_OR, 5'd4, 5'd1, 12'h80F));
      put(op_imm(rv_isa_pkg::F3_AND, 5'd5, 5'd4, 12'hF0F));
      put(op_reg(rv_isa_pkg::F3_XOR, 1'b0, 5'd6, 5'd1, 5'd2));
      put(op_reg(rv_isa_pkg::F3_OR, 1'b0, 5'd7, 5'd4, 5'd2));
      put(op_reg(rv_isa_pkg::F3_AND, 1'b0, 5'd8, 5'd3, 5'd4));
      // Write to x0 must be dropped
      put(op_imm(rv_isa_pkg::F3_ADD_SUB_BEQ, 5'd0, 5'd1, 12'h005));
      put(sw(5'd3, 5'd0, 12'h000));
      put(sw(5'd4, 5'd0, 12'h004));
      put(sw(5'd5, 5'd0, 12'h008));
      put(sw(5'd6, 5'd0, 12'h00C));
      put(sw(5'd7, 5'd0, 12'h010));
      put(sw(5'd8, 5'd0, 12'h014));
      put(sw(5'd2, 5'd0, 12'h018));
      put(sw(5'd0, 5'd0, 12'h01C));
      put(jal(5'd0, 21'd0));
      release_program();
      check_store(32'h00, r3);
      check_store(32'h04, r4);
      check_store(32'h08, r4 & sext12(12'hF0F));
      check_store(32'h0C, r1 ^ r2);
      check_store(32'h10, r4 | r2);
      check_store(32'h14, r3 & r4);
      check_store(32'h18, r2);
      check_store(32'h1C, 32'h0);
   endtask

   task automatic branches();
      begin_program();
      put(op_imm(rv_isa_pkg::F3_ADD_SUB_BEQ, 5'd1, 5'd0, 12'h007));
      put(op_imm(rv_isa_pkg::F3_ADD_SUB_BEQ, 5'd2, 5'd0, 12'h007));
      put(branch(rv_isa_pkg::F3_ADD_SUB_BEQ, 5'd1, 5'd2, 13'd12));
      put(op_imm(rv_isa_pkg::F3_ADD_SUB_BEQ, 5'd0, 5'd0, 12'h000));
      put(op_imm(rv_isa_pkg::F3_ADD_SUB_BEQ, 5'd0, 5'd0, 12'h000));
      put(branch(rv_isa_pkg::F3_BNE, 5'd1, 5'd2, 13'd8));
      put(op_imm(rv_isa_pkg::F3_ADD_SUB_BEQ, 5'd3, 5'd0, 12'h009));
      put(branch(rv_isa_pkg::F3_ADD_SUB_BEQ, 5'd1, 5'd3, 13'd8));
      put(branch(rv_isa_pkg::F3_BNE, 5'd1, 5'd3, 13'd16));
      load_idx = START_PC[7:2] + 12;
      put(jal(5'd0, 21'd0));
      release_program();
      check_fetch(START_PC);
      check_fetch(START_PC + 32'd4);
      check_fetch(START_PC + 32'd8);
      check_fetch(START_PC + 32'd8 + 32'd12);
      check_fetch(START_PC + 32'd20 + 32'd4);
      check_fetch(START_PC + 32'd24 + 32'd4);
      check_fetch(START_PC + 32'd28 + 32'd4);
      check_fetch(START_PC + 32'd32 + 32'd16);
      check_fetch(START_PC + 32'd48);
   endtask

   task automatic jump_and_link();
      begin_program();
      put(jal(5'd1, 21'd16));
      put(op_imm(rv_isa_pkg::F3_ADD_SUB_BEQ, 5'd0, 5'd0, 12'h000));
      put(sw(5'd2, 5'd0, 12'h104));
      put(jal(5'd0, 21'd0));
      put(sw(5'd1, 5'd0, 12'h100));
      put(jal(5'd2, -21'sd12));
      release_program();
      check_fetch(START_PC);
      check_fetch(START_PC + 32'd16);
      check_fetch(START_PC + 32'd20);
      check_fetch(START_PC + 32'd20 - 32'd12);
      check_fetch(START_PC + 32'd12);
      check_store(32'h100, START_PC + 32'd4);
      check_store(32'h104, START_PC + 32'd20 + 32'd4);
   endtask

   task automatic stalled_buses();
      stall_en = 1'b1;
      arithmetic();
      logic_and_lui();
      branches();
      jump_and_link();
   endtask

   initial begin
      i_rst_n    = 1'b0;
      i_ibus_rdt = '0;
      i_ibus_ack = 1'b0;
      i_dbus_ack = 1'b0;
      seed       = 32'hd519;
      stall_en   = 1'b0;
      first_fetch();
      arithmetic();
      logic_and_lui();
      branches();
      jump_and_link();
      stalled_buses();
      run_over = 1'b1;
      errors += UUT.bus_chk.fail_cnt;
      $display("Tests done with %0d errors", errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      run_over = 1'b1;
      $display("Watchdog expired after %0d ns with %0d errors", WATCHDOG_NS, errors);
      $display("Simulation failed");
      $finish;
   end

   // Run stopped early by a failing bus assertion
   final begin
      if (!run_over) begin
         $display("Simulation failed");
      end
   end

endmodule
